// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/pc_gen.sv
      - hw/inst_queue.sv
      - hw/predecode.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - verification/fetch_chk.sv
      - verification/fetch_tb.sv

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // one queue slot, pc sits in the upper half
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    // major opcode classes of rv32i
    typedef enum logic [3:0] {
        OP_LUI     = 4'd0,
        OP_AUIPC   = 4'd1,
        OP_JAL     = 4'd2,
        OP_JALR    = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_LOAD    = 4'd5,
        OP_STORE   = 4'd6,
        OP_IMM     = 4'd7,
        OP_REG     = 4'd8,
        OP_FENCE   = 4'd9,
        OP_SYSTEM  = 4'd10,
        OP_ILLEGAL = 4'd15  // anything not listed above
    } opcode_e;

    // raw inst[6:0] values
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // what decode hands to the back end
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        opcode_e     op;
        logic [31:0] imm;   // sign extended per format
    } fetch_packet_t;

endpackage

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h0000_1000,
    parameter int unsigned QUEUE_DEPTH = 8
) (
    input  logic          clk,
    input  logic          arst_n,
    // instruction memory
    output logic [31:0]   imem_addr,
    output logic          imem_read,
    input  logic [31:0]   imem_rdata,
    input  logic          imem_resp,
    // back end
    input  logic          redirect_en,
    input  logic [31:0]   redirect_pc,
    input  logic          deq_req,
    output fetch_packet_t packet,
    output logic          packet_valid
);

    fetch_entry_t wr_entry;
    fetch_entry_t rd_entry;
    logic         wr_en;
    logic         rd_en;
    logic         flush;
    logic         empty;
    logic         full;
    logic         jal_redirect;
    logic [31:0]  jal_target;

    // producer, one read at a time
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk          (clk),
        .arst_n       (arst_n),
        .redirect_en  (redirect_en),
        .redirect_pc  (redirect_pc),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target),
        .queue_full   (full),
        .imem_addr    (imem_addr),
        .imem_read    (imem_read),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .wr_entry     (wr_entry),
        .wr_en        (wr_en),
        .flush        (flush)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_inst_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .rd_entry (rd_entry),
        .empty    (empty),
        .full     (full)
    );

    // consumer, pops on deq_req
    predecode i_predecode (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .deq_req      (deq_req),
        .empty        (empty),
        .rd_entry     (rd_entry),
        .rd_en        (rd_en),
        .packet       (packet),
        .packet_valid (packet_valid),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target)
    );

endmodule

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
import fetch_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 8   // power of two, at least 2
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  logic         wr_en,
    input  fetch_entry_t wr_entry,
    input  logic         rd_en,
    output fetch_entry_t rd_entry,
    output logic         empty,
    output logic         full
);

    localparam int unsigned AW = $clog2(QUEUE_DEPTH);

    // extra msb is the wrap bit
    logic [AW:0]  wr_ptr;
    logic [AW:0]  rd_ptr;
    logic         do_wr;
    logic         do_rd;
    fetch_entry_t mem [QUEUE_DEPTH];

    // flush wins over both sides
    assign do_wr = wr_en && !full && !flush;
    assign do_rd = rd_en && !empty && !flush;

    // same slot, wrap bits tell full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // head is always visible
    assign rd_entry = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;   // both back to slot 0, queue empty
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen
import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         redirect_en,   // mispredict from back end
    input  logic [31:0]  redirect_pc,
    input  logic         jal_redirect,  // early redirect from predecode
    input  logic [31:0]  jal_target,
    input  logic         queue_full,
    output logic [31:0]  imem_addr,
    output logic         imem_read,
    input  logic [31:0]  imem_rdata,
    input  logic         imem_resp,
    output fetch_entry_t wr_entry,
    output logic         wr_en,
    output logic         flush
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,   // read outstanding, response wanted
        FETCH_DROP    // read outstanding, response is wrong path
    } fetch_state_e;

    fetch_state_e state, state_next;
    logic [31:0]  pc;

    // either redirect kills everything younger
    assign flush = redirect_en | jal_redirect;

    // pc only moves on resp or redirect, both of which leave WAIT,
    // so the address holds for the whole request
    assign imem_addr = pc;
    assign imem_read = (state == FETCH_WAIT);

    assign wr_en    = (state == FETCH_WAIT) && imem_resp && !flush;
    assign wr_entry = '{pc: pc, inst: imem_rdata};

    always_comb begin
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (!flush && !queue_full) state_next = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                if (imem_resp) state_next = FETCH_IDLE;   // taken or dropped in place
                else if (flush) state_next = FETCH_DROP;
            end
            FETCH_DROP: begin
                if (imem_resp) state_next = FETCH_IDLE;   // stale word eaten
            end
            default: state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // external redirect wins over jal
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (redirect_en) begin
            pc <= redirect_pc;
        end else if (jal_redirect) begin
            pc <= jal_target;
        end else if (wr_en) begin
            pc <= pc + 32'd4;   // next sequential word
        end
    end

endmodule

// File: hw/predecode.sv
`timescale 1ns/1ps

module predecode
import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          deq_req,
    input  logic          empty,
    input  fetch_entry_t  rd_entry,
    output logic          rd_en,
    output fetch_packet_t packet,
    output logic          packet_valid,
    output logic          jal_redirect,
    output logic [31:0]   jal_target
);

    opcode_e     op_dec;
    logic [31:0] imm_dec;
    logic [31:0] inst;

    assign inst = rd_entry.inst;

    // hold off popping while the jal flush is in flight
    assign rd_en = deq_req && !empty && !jal_redirect;

    // opcode class
    always_comb begin
        case (inst[6:0])
            OPC_LUI:    op_dec = OP_LUI;
            OPC_AUIPC:  op_dec = OP_AUIPC;
            OPC_JAL:    op_dec = OP_JAL;
            OPC_JALR:   op_dec = OP_JALR;
            OPC_BRANCH: op_dec = OP_BRANCH;
            OPC_LOAD:   op_dec = OP_LOAD;
            OPC_STORE:  op_dec = OP_STORE;
            OPC_IMM:    op_dec = OP_IMM;
            OPC_REG:    op_dec = OP_REG;
            OPC_FENCE:  op_dec = OP_FENCE;
            OPC_SYSTEM: op_dec = OP_SYSTEM;
            default:    op_dec = OP_ILLEGAL;
        endcase
    end

    // immediate by format
    always_comb begin
        case (op_dec)
            OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM:           // I
                imm_dec = {{20{inst[31]}}, inst[31:20]};
            OP_STORE:                                      // S
                imm_dec = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OP_BRANCH:                                     // B
                imm_dec = {{19{inst[31]}}, inst[31], inst[7],
                           inst[30:25], inst[11:8], 1'b0};
            OP_LUI, OP_AUIPC:                              // U
                imm_dec = {inst[31:12], 12'b0};
            OP_JAL:                                        // J
                imm_dec = {{11{inst[31]}}, inst[31], inst[19:12],
                           inst[20], inst[30:21], 1'b0};
            default:
                imm_dec = '0;   // reg, fence, illegal
        endcase
    end

    // control, a pop during flush is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet_valid <= 1'b0;
            jal_redirect <= 1'b0;
        end else begin
            packet_valid <= rd_en && !flush;
            jal_redirect <= rd_en && !flush && (op_dec == OP_JAL);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (rd_en) begin
            packet <= '{pc: rd_entry.pc, inst: inst, op: op_dec, imm: imm_dec};
        end
    end

    // only meaningful while jal_redirect is up
    assign jal_target = packet.pc + packet.imm;

endmodule

// File: list.f
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/inst_queue.sv
hw/predecode.sv
hw/fetch_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

// File: verification/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
    input logic        clk,
    input logic        arst_n,
    input logic        wr_en,
    input logic        full,
    input logic        rd_en,
    input logic        empty,
    input logic        flush,
    input logic        imem_read,
    input logic        imem_resp,
    input logic [31:0] imem_addr
);

    // queue side
    a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(wr_en && full))
        else $error("write into a full instruction queue");

    a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !(rd_en && empty))
        else $error("read from an empty instruction queue");

    // request side, address holds until the answer or a redirect
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        imem_read && !imem_resp && !flush |=> imem_read && $stable(imem_addr))
        else $error("imem_addr moved while a read was open");

    a_idle_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !imem_read)
        else $error("imem_read high right after a flush");

endmodule

// queue view, memory ports unused there
bind inst_queue fetch_chk i_queue_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .full      (full),
    .rd_en     (rd_en),
    .empty     (empty),
    .flush     (flush),
    .imem_read (1'b0),
    .imem_resp (1'b0),
    .imem_addr (32'h0)
);

// producer view, sees full through queue_full
bind pc_gen fetch_chk i_req_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .full      (queue_full),
    .rd_en     (1'b0),
    .empty     (1'b0),
    .flush     (flush),
    .imem_read (imem_read),
    .imem_resp (imem_resp),
    .imem_addr (imem_addr)
);

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
import fetch_pkg::*;
();

    localparam logic [31:0] RESET_PC    = 32'h0000_1000;
    localparam int unsigned QUEUE_DEPTH = 8;
    localparam int MAX_CYCLES = 4000;   // five tests take a few hundred cycles, rest is margin
    localparam int PKT_WAIT   = 100;    // per packet

    logic          clk;
    logic          arst_n;
    logic [31:0]   imem_addr;
    logic          imem_read;
    logic [31:0]   imem_rdata;
    logic          imem_resp;
    logic          redirect_en;
    logic [31:0]   redirect_pc;
    logic          deq_req;
    fetch_packet_t packet;
    logic          packet_valid;

    int            errors = 0;
    int            checks = 0;
    int            cycle_count = 0;
    int            resp_due = 0;        // cycle in which the pending response is driven
    int            last_pkt_cyc;
    logic [31:0]   lfsr_state = 32'h8eb6;
    logic [31:0]   tab_addr [32];       // sparse program table
    logic [31:0]   tab_word [32];
    int            tab_n = 0;
    logic [31:0]   served_q [$];        // every address the memory answered
    fetch_packet_t pkt_q [$];
    int            pkt_cyc_q [$];

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_fetch_top (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // packet monitor, outputs are registered so negedge is quiet
    always @(negedge clk) begin
        if (arst_n && packet_valid) begin
            pkt_q.push_back(packet);
            pkt_cyc_q.push_back(cycle_count);
        end
    end

    // 32 bit fibonacci, taps 32 22 2 1
    function automatic int lfsr_take(input int nbits);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = (val << 1) | fb;
        end
        return val;
    endfunction

    // table hit, else addi whose imm is addr[11:2], rd folds the upper bits
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [4:0] fold;
        for (int i = 0; i < tab_n; i++) begin
            if (tab_addr[i] == addr) return tab_word[i];
        end
        fold = addr[16:12] ^ addr[21:17] ^ addr[26:22] ^ addr[31:27];
        return {2'b00, addr[11:2], 5'd0, 3'b000, fold, OPC_IMM};
    endfunction

    // memory, one read at a time, 1 to 4 cycles
    initial begin : mem_model
        int          lat;
        logic [31:0] addr;
        imem_resp  = 1'b0;
        imem_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (imem_read === 1'b1) begin
                addr = imem_addr;   // latched, pc may move on a redirect
                lat = 1 + lfsr_take(2);
                resp_due = cycle_count + lat - 1;
                repeat (lat - 1) begin
                    @(posedge clk);
                    #2;
                end
                imem_rdata = mem_word(addr);
                imem_resp  = 1'b1;
                served_q.push_back(addr);
                @(posedge clk);
                #2;
                imem_resp = 1'b0;
            end
        end
    end

    function automatic opcode_e ref_op(input logic [31:0] w);
        case (w[6:0])
            OPC_LUI:    return OP_LUI;
            OPC_AUIPC:  return OP_AUIPC;
            OPC_JAL:    return OP_JAL;
            OPC_JALR:   return OP_JALR;
            OPC_BRANCH: return OP_BRANCH;
            OPC_LOAD:   return OP_LOAD;
            OPC_STORE:  return OP_STORE;
            OPC_IMM:    return OP_IMM;
            OPC_REG:    return OP_REG;
            OPC_FENCE:  return OP_FENCE;
            OPC_SYSTEM: return OP_SYSTEM;
            default:    return OP_ILLEGAL;
        endcase
    endfunction

    // sx[i] is w[i+20], sign filled above
    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        logic [6:0]  opc;
        logic [31:0] sx;
        opc = w[6:0];
        sx  = $signed(w) >>> 20;
        if (opc == OPC_LUI || opc == OPC_AUIPC) return {w[31:12], 12'h000};
        if (opc == OPC_JALR || opc == OPC_LOAD || opc == OPC_IMM || opc == OPC_SYSTEM) return sx;
        if (opc == OPC_STORE) return {sx[31:5], w[11:7]};
        if (opc == OPC_BRANCH) return {sx[31:12], w[7], sx[10:5], w[11:8], 1'b0};
        if (opc == OPC_JAL) return {sx[31:20], w[19:12], w[20], sx[10:1], 1'b0};
        return 32'h0;   // reg, fence, illegal
    endfunction

    function automatic logic [31:0] enc_j(input int off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};   // rd = ra
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic place(input logic [31:0] addr, input logic [31:0] word);
        tab_addr[tab_n] = addr;
        tab_word[tab_n] = word;
        tab_n++;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        redirect_en = 1'b1;
        redirect_pc = target;
        step(1);
        redirect_en = 1'b0;
        pkt_q.delete();   // anything left is from the old path
        pkt_cyc_q.delete();
    endtask

    task automatic get_packet(output fetch_packet_t p, output bit got);
        int waited;
        waited = 0;
        got = 1'b0;
        p = '0;
        while (pkt_q.size() == 0 && waited < PKT_WAIT) begin
            step(1);
            waited++;
        end
        if (pkt_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t ns: no packet came out within %0d cycles", $time, PKT_WAIT);
        end else begin
            p = pkt_q.pop_front();
            last_pkt_cyc = pkt_cyc_q.pop_front();
            got = 1'b1;
        end
    endtask

    task automatic expect_packet(input logic [31:0] exp_pc, output fetch_packet_t p,
                                 output bit got);
        logic [31:0] w;
        get_packet(p, got);
        if (got) begin
            w = mem_word(exp_pc);
            check_equal(p.pc, exp_pc, "packet pc");
            check_equal(p.inst, w, $sformatf("inst at pc %h", exp_pc));
            check_equal(32'(p.op), 32'(ref_op(w)), $sformatf("op at pc %h", exp_pc));
            check_equal(p.imm, ref_imm(w), $sformatf("imm at pc %h", exp_pc));
        end
    endtask

    task automatic test_sequential();
        fetch_packet_t p;
        bit            got;
        deq_req = 1'b1;
        for (int i = 0; i < 20; i++) begin
            expect_packet(RESET_PC + 4 * i, p, got);
        end
        deq_req = 1'b0;
    endtask

    task automatic test_backpressure();
        int            low;
        int            n;
        int            taken;
        int            prev;
        fetch_packet_t p;
        bit            got;
        redirect_to(32'h0000_2000);
        served_q.delete();
        low = 0;
        n = 0;
        while (low < 10 && n < 300) begin   // wait for the fetch side to go quiet
            step(1);
            n++;
            low = imem_read ? 0 : low + 1;
        end
        if (low < 10) begin
            errors++;
            $display("ERROR at %0t ns: imem_read never went quiet with deq_req low", $time);
        end
        taken = 0;
        foreach (served_q[i]) begin
            if (served_q[i][31:8] == 24'h000020) taken++;   // new path only
        end
        check_equal(taken, QUEUE_DEPTH, "responses accepted under back-pressure");
        check_equal(pkt_q.size(), 0, "packets with deq_req low");
        deq_req = 1'b1;
        prev = 0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            expect_packet(32'h2000 + 4 * i, p, got);
            if (got && i > 0) check_equal(last_pkt_cyc - prev, 1, "drain spacing");
            prev = last_pkt_cyc;
        end
        deq_req = 1'b0;
    endtask

    task automatic test_ext_redirect();
        int            tries;
        fetch_packet_t p;
        bit            got;
        redirect_to(32'h0000_3000);
        deq_req = 1'b1;
        for (int i = 0; i < 4; i++) begin
            expect_packet(32'h3000 + 4 * i, p, got);
        end
        // look for a read whose answer is still two or more cycles out
        tries = 0;
        @(negedge clk);
        while (!(imem_read && resp_due >= cycle_count + 2) && tries < 60) begin
            @(negedge clk);
            tries++;
        end
        if (tries >= 60) begin
            errors++;
            $display("ERROR at %0t ns: no outstanding read found for the redirect", $time);
        end
        step(1);
        redirect_to(32'h0000_3800);
        for (int i = 0; i < 6; i++) begin
            expect_packet(32'h3800 + 4 * i, p, got);
        end
        deq_req = 1'b0;
    endtask

    task automatic test_jal_redirect();
        logic [31:0]   pcs [11];
        fetch_packet_t p;
        bit            got;
        pcs = '{32'h4000, 32'h4004, 32'h4008, 32'h400C, 32'h4010, 32'h4110,
                32'h4114, 32'h4118, 32'h4098, 32'h409C, 32'h40A0};
        redirect_to(32'h0000_4000);
        deq_req = 1'b1;
        foreach (pcs[i]) begin
            expect_packet(pcs[i], p, got);
        end
        deq_req = 1'b0;
    endtask

    task automatic test_opcodes();
        logic [31:0]   pcs [12];
        opcode_e       ops [12];
        fetch_packet_t p;
        bit            got;
        pcs = '{32'h5000, 32'h5004, 32'h5008, 32'h500C, 32'h5010, 32'h5014,
                32'h5018, 32'h501C, 32'h5020, 32'h5024, 32'h5028, 32'h5030};
        ops = '{OP_LUI, OP_AUIPC, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                OP_IMM, OP_REG, OP_FENCE, OP_SYSTEM, OP_JAL, OP_ILLEGAL};
        redirect_to(32'h0000_5000);
        deq_req = 1'b1;
        foreach (pcs[i]) begin
            expect_packet(pcs[i], p, got);
            if (got) check_equal(32'(p.op), 32'(ops[i]), "op class");
        end
        if (got) check_equal(p.imm, 32'h0, "illegal immediate");
        deq_req = 1'b0;
    endtask

    initial begin
        arst_n      = 1'b0;
        redirect_en = 1'b0;
        redirect_pc = '0;
        deq_req     = 1'b0;
        place(32'h4010, enc_j(32'h100));   // forward jump
        place(32'h4118, enc_j(-128));      // backward jump
        place(32'h5000, 32'hABCDE1B7);     // lui x3
        place(32'h5004, 32'h80001217);     // auipc x4
        place(32'h5008, 32'hFFC080E7);     // jalr -4
        place(32'h500C, 32'hFE208EE3);     // beq, negative offset
        place(32'h5010, 32'h80012283);     // lw -2048
        place(32'h5014, 32'hF8112E23);     // sw, negative offset
        place(32'h5018, 32'h7FF00093);     // addi 2047
        place(32'h501C, 32'h402081B3);     // sub
        place(32'h5020, 32'h0FF0000F);     // fence
        place(32'h5024, 32'h00100073);     // ebreak
        place(32'h5028, enc_j(8));         // skips 0x502c
        place(32'h5030, 32'hF0F0F0FF);     // opcode 7f, not rv32i
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_sequential();
        test_backpressure();
        test_ext_redirect();
        test_jal_redirect();
        test_opcodes();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
